/* Makefile */
VERILATOR ?= verilator
TOP       ?= spi_bus_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= *** FAILED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q -F -- '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulation exited with status $$status"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+.
spi_bus_pkg.sv
spi_cmd_receiver.sv
spi_bus_owner_ctrl.sv
spi_bus_router.sv
spi_bus.sv
spi_bus_props.sv
spi_bus_tb.sv

/* spi_bus.sv */
// ================================================
// Two SPI masters sharing one SPI memory, mode 0.
// Pin to memory latency is 3 clk; sck <= clk/8.
// ================================================
`timescale 1ns/100ps
`default_nettype none

module spi_bus import spi_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // Main master, which also sends the control commands.
  input  spi_lines_t main_spi,
  output logic       main_miso,
  // Alternate master.
  input  spi_lines_t alt_spi,
  output logic       alt_miso,
  // Shared memory.
  output spi_lines_t mem_spi,
  input  logic       mem_miso
);

  // Synchronized copies of both masters.
  spi_lines_t main_sync;
  spi_lines_t alt_sync;

  // Command strobes from the main port.
  spi_cmd_t cmd;

  // Steering state.
  bus_owner_e owner;
  logic       main_pass;

  spi_cmd_receiver u_receiver (
    .clk       (clk),
    .rst       (rst),
    .main_spi  (main_spi),
    .main_sync (main_sync),
    .cmd       (cmd)
  );

  spi_bus_owner_ctrl u_owner_ctrl (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .main_sync (main_sync),
    .alt_sync  (alt_sync),
    .owner     (owner),
    .main_pass (main_pass)
  );

  spi_bus_router u_router (
    .clk       (clk),
    .rst       (rst),
    .main_sync (main_sync),
    .alt_spi   (alt_spi),
    .alt_sync  (alt_sync),
    .owner     (owner),
    .main_pass (main_pass),
    .mem_spi   (mem_spi),
    .mem_miso  (mem_miso),
    .main_miso (main_miso),
    .alt_miso  (alt_miso)
  );

endmodule

`default_nettype wire

/* spi_bus_cfg.svh */
// ================================================
// Widths and command codes for the SPI bus switch.
// Codes are compared whole; others are ignored.
// ================================================
`ifndef SPI_BUS_CFG_SVH
`define SPI_BUS_CFG_SVH

// Number of bits shifted per SPI byte, MSB first.
`define SPI_BYTE_WIDTH 8

// Depth of the input synchronizers on every SPI line.
// The pin to mem_spi latency grows one cycle per added stage.
`define SPI_SYNC_STAGES 2

// Command codes, sent as the first byte of a main port transaction.

// Hands the memory to the main port after the current main transaction.
`define SPI_CMD_MAIN_BUS 8'hA0

// Hands the memory to the alt port after the current main transaction.
// The change waits for the alt port to be idle.
`define SPI_CMD_ALT_BUS 8'hA1

// Opens a pass-through for the rest of the current main transaction.
// It only has effect while the main port owns the memory.
`define SPI_CMD_MEMORY 8'hA2

`endif

/* spi_bus_input.txt */
# port (0 main, 1 alt), byte count, four hex bytes (unused ones 00),
# expected number of bytes forwarded to the memory
0 3 A2 5A C3 00 2
1 2 11 22 00 00 0
0 2 A2 E7 00 00 1
0 1 A1 00 00 00 0
1 3 3C 96 0F 00 3
0 3 A2 12 34 00 0
1 1 81 00 00 00 1
0 2 7E 55 00 00 0
1 2 AA 01 00 00 2
0 1 A0 00 00 00 0
1 2 FF 00 00 00 0
0 4 A2 01 80 FE 3
0 2 33 A2 00 00 0
0 3 A2 9C 00 00 2
0 1 A2 00 00 00 0
1 1 5A 00 00 00 0

/* spi_bus_owner_ctrl.sv */
// ================================================
// Ownership changes wait for main nss high and alt idle.
// Pass-through opens on a main sck falling edge.
// ================================================
`timescale 1ns/100ps
`default_nettype none

`include "spi_bus_cfg.svh"

module spi_bus_owner_ctrl import spi_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  spi_cmd_t   cmd,
  input  spi_lines_t main_sync,
  input  spi_lines_t alt_sync,
  output bus_owner_e owner,
  output logic       main_pass
);

  // Requested owner, held until the command transaction ends.
  bus_owner_e pend_owner;
  logic       pend_valid;
  // Set once the requesting transaction has ended.
  logic       pend_ready;

  // MEMORY was accepted and the pass-through waits for a falling sck.
  logic pass_armed;
  logic sck_q;
  logic sck_fall;

  // Decoded command of the current cycle.
  logic       bus_cmd;
  bus_owner_e bus_req;
  logic       mem_cmd;

  always_comb begin
    bus_cmd = 1'b0;
    bus_req = OWNER_MAIN;
    mem_cmd = 1'b0;
    if (cmd.valid) begin
      case (cmd.code)
        `SPI_CMD_MAIN_BUS: begin
          bus_cmd = 1'b1;
          bus_req = OWNER_MAIN;
        end
        `SPI_CMD_ALT_BUS: begin
          bus_cmd = 1'b1;
          bus_req = OWNER_ALT;
        end
        `SPI_CMD_MEMORY: begin
          mem_cmd = 1'b1;
        end
        // Unknown codes leave every register alone.
        default: begin
        end
      endcase
    end
  end

  assign sck_fall = ~main_sync.sck & sck_q;

  // Owner handover.
  always_ff @(posedge clk) begin
    if (rst) begin
      owner      <= OWNER_MAIN;
      pend_owner <= OWNER_MAIN;
      pend_valid <= 1'b0;
      pend_ready <= 1'b0;
    end else if (bus_cmd) begin
      // A newer request replaces one that has not been applied yet.
      pend_owner <= bus_req;
      pend_valid <= 1'b1;
      pend_ready <= 1'b0;
    end else if (cmd.xfer_end && pend_valid) begin
      pend_ready <= 1'b1;
    end else if (pend_ready && alt_sync.nss) begin
      // Alt nss is high here, so no alt transaction is cut in two.
      owner      <= pend_owner;
      pend_valid <= 1'b0;
      pend_ready <= 1'b0;
    end
  end

  // Pass-through for the remainder of a main MEMORY transaction.
  always_ff @(posedge clk) begin
    if (rst) begin
      sck_q      <= 1'b0;
      pass_armed <= 1'b0;
      main_pass  <= 1'b0;
    end else begin
      sck_q <= main_sync.sck;
      if (cmd.xfer_end) begin
        pass_armed <= 1'b0;
        main_pass  <= 1'b0;
      end else if (mem_cmd && owner == OWNER_MAIN) begin
        pass_armed <= 1'b1;
      end else if (pass_armed && sck_fall) begin
        // sck is low now, so the memory never sees a cut clock pulse.
        pass_armed <= 1'b0;
        main_pass  <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* spi_bus_pkg.sv */
// ================================================
// Shared types of the SPI bus switch, SPI mode 0 only.
// ================================================
`default_nettype none

`include "spi_bus_cfg.svh"

package spi_bus_pkg;

  // The three lines that a SPI master drives.
  // miso travels on its own since it runs the other way.
  typedef struct packed {
    logic nss;
    logic sck;
    logic mosi;
  } spi_lines_t;

  // Level of an undriven mode 0 bus, with select high and clock low.
  localparam spi_lines_t SPI_LINES_IDLE = '{nss: 1'b1, sck: 1'b0, mosi: 1'b0};

  // Which master currently owns the memory port.
  typedef enum logic {
    OWNER_MAIN = 1'b0,
    OWNER_ALT  = 1'b1
  } bus_owner_e;

  // Command byte from the main port.
  // valid strobes for one cycle when the first byte of a transaction is complete.
  // xfer_end strobes for one cycle when the synchronized main nss rises.
  typedef struct packed {
    logic                       valid;
    logic [`SPI_BYTE_WIDTH-1:0] code;
    logic                       xfer_end;
  } spi_cmd_t;

endpackage

`default_nettype wire

/* spi_bus_props.sv */
// ==================================================
// Steering checks bound into the switch top level.
// ==================================================
`timescale 1ns/100ps
`default_nettype none

module spi_bus_props import spi_bus_pkg::*; (
  input logic       clk,
  input logic       rst,
  input bus_owner_e owner,
  input logic       main_pass,
  input spi_lines_t alt_sync,
  input spi_lines_t mem_spi,
  input logic       main_miso
);

  // Each property counts its own failures.
  int idle_fails = 0;
  int owner_fails = 0;
  int miso_fails = 0;

  // With no forwarding source the memory stays deselected.
  idle_nss: assert property (@(posedge clk) disable iff (rst)
    (!main_pass && owner != OWNER_ALT) |-> mem_spi.nss)
    else begin
      idle_fails++;
      $error("memory selected while nothing is forwarded");
    end

  // A handover never lands inside an alt transaction.
  owner_hold: assert property (@(posedge clk) disable iff (rst)
    !alt_sync.nss |=> $stable(owner))
    else begin
      owner_fails++;
      $error("owner changed while alt nss was low");
    end

  // The main master only hears the memory through the pass-through.
  main_quiet: assert property (@(posedge clk) disable iff (rst)
    !main_pass |-> !main_miso)
    else begin
      miso_fails++;
      $error("main_miso high without pass-through");
    end

endmodule

bind spi_bus spi_bus_props u_props (
  .clk       (clk),
  .rst       (rst),
  .owner     (owner),
  .main_pass (main_pass),
  .alt_sync  (alt_sync),
  .mem_spi   (mem_spi),
  .main_miso (main_miso)
);

`default_nettype wire

/* spi_bus_router.sv */
// ================================================
// Registered steering to the memory port.
// miso returns combinationally; assumes sck <= clk/8.
// ================================================
`timescale 1ns/100ps
`default_nettype none

`include "spi_bus_cfg.svh"

module spi_bus_router import spi_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  spi_lines_t main_sync,
  input  spi_lines_t alt_spi,
  output spi_lines_t alt_sync,
  input  bus_owner_e owner,
  input  logic       main_pass,
  output spi_lines_t mem_spi,
  input  logic       mem_miso,
  output logic       main_miso,
  output logic       alt_miso
);

  // The alt port synchronizer has the same depth as the one on the main port.
  spi_lines_t [`SPI_SYNC_STAGES-1:0] alt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `SPI_SYNC_STAGES; i++) begin
        alt_q[i] <= SPI_LINES_IDLE;
      end
    end else begin
      alt_q[0] <= alt_spi;
      for (int i = 1; i < `SPI_SYNC_STAGES; i++) begin
        alt_q[i] <= alt_q[i-1];
      end
    end
  end

  assign alt_sync = alt_q[`SPI_SYNC_STAGES-1];

  // One register stage to the memory pins.
  // The pass-through takes priority, though the controller never sets both.
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_spi <= SPI_LINES_IDLE;
    end else if (main_pass) begin
      mem_spi <= main_sync;
    end else if (owner == OWNER_ALT) begin
      mem_spi <= alt_sync;
    end else begin
      mem_spi <= SPI_LINES_IDLE;
    end
  end

  // The port that is not forwarded reads 0.
  always_comb begin
    main_miso = main_pass & mem_miso;
    alt_miso  = (owner == OWNER_ALT) & ~main_pass & mem_miso;
  end

endmodule

`default_nettype wire

/* spi_bus_tb.sv */
// ==================================================
// Data-driven testbench for the SPI bus switch.
// Reads spi_bus_input.txt from the working directory.
// ==================================================
`timescale 1ns/100ps
`default_nettype none

`include "spi_bus_cfg.svh"

module spi_bus_tb import spi_bus_pkg::*; ();

  localparam int BW = `SPI_BYTE_WIDTH;
  localparam int MAX_TRANS = 32;
  localparam int MAX_BYTES = 4;
  // Each sck half period lasts HALF clk cycles, so sck runs at clk/8.
  localparam int HALF = 4;

  logic       clk;
  logic       rst;
  spi_lines_t main_spi;
  spi_lines_t alt_spi;
  spi_lines_t mem_spi;
  logic       main_miso;
  logic       alt_miso;
  logic       mem_miso;

  // Transactions from the data file; port 0 is main and port 1 is alt.
  int            n_trans;
  int            tr_port [MAX_TRANS];
  int            tr_count [MAX_TRANS];
  int            tr_expect [MAX_TRANS];
  logic [BW-1:0] tr_bytes [MAX_TRANS][MAX_BYTES];

  // Reference model owner, the predicted forward flags, and miso seen per byte.
  bus_owner_e    model_owner;
  logic          fwd [MAX_BYTES];
  logic [BW-1:0] miso_rx [MAX_BYTES];

  // Memory model state. Bytes land in mem_rx in arrival order.
  logic [BW-1:0] mem_shift;
  int            mem_bits = 0;
  logic          mem_sck_q = 1'b0;
  logic [BW-1:0] mem_rx [$];

  logic [31:0] rng = 32'hc9ee0768;
  int          cycle_cnt = 0;
  int          cycle_limit = 100000;

  spi_bus uut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // The memory answers every bit with the inverse of what it receives.
  assign mem_miso = ~mem_spi.mosi;

  // Sampled on the falling clk edge, where the registered mem_spi is settled.
  always @(negedge clk) begin
    mem_sck_q <= mem_spi.sck;
    if (mem_spi.nss) begin
      mem_bits <= 0;
    end else if (mem_spi.sck && !mem_sck_q) begin
      mem_shift <= {mem_shift[BW-2:0], mem_spi.mosi};
      mem_bits  <= (mem_bits == BW - 1) ? 0 : mem_bits + 1;
      if (mem_bits == BW - 1) begin
        mem_rx.push_back({mem_shift[BW-2:0], mem_spi.mosi});
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      stop_on_error("timeout: the transactions did not finish in time");
    end
    if (uut.u_props.idle_fails + uut.u_props.owner_fails + uut.u_props.miso_fails != 0) begin
      stop_on_error("a concurrent assertion on the DUT failed");
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_byte(input logic [BW-1:0] got, input logic [BW-1:0] exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_lines(input spi_lines_t got, input spi_lines_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: %s are %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      stop_on_error($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Waits n rising edges, then the drive delay after the last one.
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  task automatic drive_port(input int port, input spi_lines_t v);
    if (port == 0) begin
      main_spi = v;
    end else begin
      alt_spi = v;
    end
  endtask

  // Lines starting with # are skipped. The time limit grows with each byte.
  task automatic read_stimulus();
    int            fd;
    int            rc;
    string         line;
    int            port;
    int            cnt;
    int            exp;
    logic [BW-1:0] b [MAX_BYTES];
    fd = $fopen("spi_bus_input.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open spi_bus_input.txt");
    end
    n_trans = 0;
    cycle_limit = 50;
    while (!$feof(fd) && n_trans < MAX_TRANS) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line[0] != "#") begin
        rc = $sscanf(line, "%d %d %h %h %h %h %d", port, cnt, b[0], b[1], b[2], b[3], exp);
        if (rc == 7) begin
          tr_port[n_trans] = port;
          tr_count[n_trans] = cnt;
          tr_expect[n_trans] = exp;
          for (int i = 0; i < MAX_BYTES; i++) begin
            tr_bytes[n_trans][i] = b[i];
          end
          cycle_limit = cycle_limit + cnt * 2 * HALF * BW + 40;
          n_trans++;
        end
      end
    end
    $fclose(fd);
    if (n_trans == 0) begin
      stop_on_error("spi_bus_input.txt holds no transactions");
    end
  endtask

  // A MEMORY command forwards the rest of a main transaction under main ownership.
  // Alt bytes pass only under alt ownership. Bus commands act after the transaction.
  task automatic predict(input int t);
    logic [BW-1:0] code;
    code = tr_bytes[t][0];
    for (int i = 0; i < MAX_BYTES; i++) begin
      fwd[i] = (tr_port[t] == 1) ? (model_owner == OWNER_ALT) :
               (i > 0 && code == `SPI_CMD_MEMORY && model_owner == OWNER_MAIN);
    end
    if (tr_port[t] == 0 && code == `SPI_CMD_MAIN_BUS) begin
      model_owner = OWNER_MAIN;
    end else if (tr_port[t] == 0 && code == `SPI_CMD_ALT_BUS) begin
      model_owner = OWNER_ALT;
    end
  endtask

  // Mode 0, MSB first. miso is taken just before each rising sck.
  task automatic run_transaction(input int t);
    spi_lines_t v;
    v = '{nss: 1'b0, sck: 1'b0, mosi: 1'b0};
    for (int i = 0; i < tr_count[t]; i++) begin
      for (int bit_idx = BW - 1; bit_idx >= 0; bit_idx--) begin
        v.sck = 1'b0;
        v.mosi = tr_bytes[t][i][bit_idx];
        drive_port(tr_port[t], v);
        wait_cycles(HALF);
        miso_rx[i][bit_idx] = (tr_port[t] == 0) ? main_miso : alt_miso;
        v.sck = 1'b1;
        drive_port(tr_port[t], v);
        wait_cycles(HALF);
      end
    end
    v.sck = 1'b0;
    drive_port(tr_port[t], v);
    wait_cycles(HALF);
    drive_port(tr_port[t], SPI_LINES_IDLE);
  endtask

  task automatic check_transaction(input int t);
    int n;
    n = 0;
    check_count(mem_rx.size(), tr_expect[t], "bytes seen at the memory");
    for (int i = 0; i < tr_count[t]; i++) begin
      if (fwd[i]) begin
        check_byte(mem_rx[n], tr_bytes[t][i], "byte at the memory");
        check_byte(miso_rx[i], ~tr_bytes[t][i], "miso byte of a forwarded byte");
        n++;
      end else begin
        check_byte(miso_rx[i], '0, "miso byte of a blocked byte");
      end
    end
    check_count(n, tr_expect[t], "model count of forwarded bytes");
    check_lines(mem_spi, SPI_LINES_IDLE, "memory lines between transactions");
  endtask

  initial begin
    rst = 1'b1;
    main_spi = SPI_LINES_IDLE;
    alt_spi = SPI_LINES_IDLE;
    model_owner = OWNER_MAIN;
    read_stimulus();
    wait_cycles(5);
    rst = 1'b0;
    wait_cycles(1);
    check_lines(mem_spi, SPI_LINES_IDLE, "memory lines after reset");
    check_bit(main_miso, 1'b0, "main_miso after reset");
    check_bit(alt_miso, 1'b0, "alt_miso after reset");
    for (int t = 0; t < n_trans; t++) begin
      mem_rx.delete();
      predict(t);
      run_transaction(t);
      // The gap also covers the pin to memory latency and any owner handover.
      rng = xorshift32(rng);
      wait_cycles(8 + int'(rng[2:0]));
      check_transaction(t);
    end
    // An assertion in the last cycle is caught here before the verdict.
    if (uut.u_props.idle_fails + uut.u_props.owner_fails + uut.u_props.miso_fails != 0) begin
      stop_on_error("a concurrent assertion on the DUT failed");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* spi_cmd_receiver.sv */
// ================================================
// Main port front end, SPI mode 0, MSB first.
// sck must stay at or below clk/8.
// ================================================
`timescale 1ns/100ps
`default_nettype none

`include "spi_bus_cfg.svh"

module spi_cmd_receiver import spi_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  spi_lines_t main_spi,
  output spi_lines_t main_sync,
  output spi_cmd_t   cmd
);

  localparam int CNT_W = $clog2(`SPI_BYTE_WIDTH);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SPI_BYTE_WIDTH - 1);

  // Synchronizer chain whose stage 0 samples the pins.
  spi_lines_t [`SPI_SYNC_STAGES-1:0] sync_q;

  // Previous synchronized levels for edge detection.
  logic sck_q;
  logic nss_q;

  // Bit position inside the first byte, and a flag once that byte is done.
  logic [CNT_W-1:0]           bit_cnt;
  logic                       byte_done;
  logic [`SPI_BYTE_WIDTH-2:0] shift_q;

  // Registered command strobe and its code.
  logic                       valid_q;
  logic [`SPI_BYTE_WIDTH-1:0] code_q;

  logic sck_rise;
  logic nss_rise;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `SPI_SYNC_STAGES; i++) begin
        sync_q[i] <= SPI_LINES_IDLE;
      end
    end else begin
      sync_q[0] <= main_spi;
      for (int i = 1; i < `SPI_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign main_sync = sync_q[`SPI_SYNC_STAGES-1];

  // Edges are seen on the synchronized lines, so mosi is already settled.
  assign sck_rise = main_sync.sck & ~sck_q;
  assign nss_rise = main_sync.nss & ~nss_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_q     <= 1'b0;
      nss_q     <= 1'b1;
      bit_cnt   <= '0;
      byte_done <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      sck_q   <= main_sync.sck;
      nss_q   <= main_sync.nss;
      valid_q <= 1'b0;
      if (main_sync.nss) begin
        // Deselected, so the next transaction starts a fresh command byte.
        bit_cnt   <= '0;
        byte_done <= 1'b0;
      end else if (sck_rise && !byte_done) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == LAST_BIT) begin
          // Later bytes of this transaction are payload and never strobe.
          byte_done <= 1'b1;
          valid_q   <= 1'b1;
        end
      end
    end
  end

  // The shift register collects the first byte while nss is low.
  always_ff @(posedge clk) begin
    if (sck_rise && !main_sync.nss && !byte_done) begin
      shift_q <= {shift_q[`SPI_BYTE_WIDTH-3:0], main_sync.mosi};
      if (bit_cnt == LAST_BIT) begin
        code_q <= {shift_q, main_sync.mosi};
      end
    end
  end

  // xfer_end is the raw edge, one cycle wide.
  always_comb begin
    cmd.valid    = valid_q;
    cmd.code     = code_q;
    cmd.xfer_end = nss_rise;
  end

endmodule

`default_nettype wire
